/* hbc_pkg.sv */
package hbc_pkg;

   // ------------------------------------------------------------------------
   // tank samples and switching surface
   // ------------------------------------------------------------------------
   typedef logic signed [13:0] adc_word_t;      // raw ADC word, two's complement
   typedef logic signed [15:0] surface_t;       // room for ic plus scaled vc

   localparam adc_word_t ADC_MAX_POS = 14'h1FFF; // positive rail
   localparam adc_word_t ADC_MAX_NEG = 14'h2000; // negative rail

   localparam int unsigned VC_SHIFT  = 2;        // vc weight in the surface
   localparam surface_t    PHI_SCALE = 16'sd64;  // window half width per degree

   // angle phi in degrees
   typedef logic [7:0] phi_t;

   localparam phi_t PHI_STEP = 8'd5;
   localparam phi_t PHI_MIN  = 8'd0;
   localparam phi_t PHI_MAX  = 8'd90;
   localparam phi_t PHI_HOME = 8'd0;

   // ------------------------------------------------------------------------
   // gate word
   // ------------------------------------------------------------------------
   localparam int unsigned GATE_W  = 4;
   localparam int unsigned LEG1_HI = 0;
   localparam int unsigned LEG2_HI = 1;
   localparam int unsigned LEG1_LO = 2;
   localparam int unsigned LEG2_LO = 3;

   typedef logic [GATE_W-1:0] gate_t;

   typedef enum logic [1:0] {SIGMA_NEG, SIGMA_ZERO, SIGMA_POS} sigma_e;

   localparam gate_t GATE_POS  = 4'b1001;  // leg1 high on, leg2 low on
   localparam gate_t GATE_NEG  = 4'b0110;  // leg2 high on, leg1 low on
   localparam gate_t GATE_ZERO = 4'b1100;  // both low sides, tank shorted
   localparam gate_t GATE_BOOT = 4'b1100;  // low sides charge the bootstraps

   // ------------------------------------------------------------------------
   // timing
   // ------------------------------------------------------------------------
   localparam int unsigned DEAD_CYCLES = 4;
   localparam int unsigned DEAD_CNT_W  = $clog2(DEAD_CYCLES);
   localparam logic [DEAD_CNT_W-1:0] DEAD_LAST = DEAD_CNT_W'(DEAD_CYCLES - 1);

   localparam int unsigned BOOT_CYCLES      = 10;
   localparam int unsigned PRECHARGE_CYCLES = 6;
   localparam int unsigned PHASE_W          = $clog2(BOOT_CYCLES); // boot is longest
   localparam logic [PHASE_W-1:0] BOOT_LAST = PHASE_W'(BOOT_CYCLES - 1);
   localparam logic [PHASE_W-1:0] PRE_LAST  = PHASE_W'(PRECHARGE_CYCLES - 1);

   typedef enum logic [1:0] {ST_IDLE, ST_BOOT, ST_PRECHARGE, ST_RUN} seq_state_e;

endpackage

/* sample_if.sv */
`timescale 1ns/1ps

// one captured sample pair, valid for a single cycle
interface sample_if;

   hbc_pkg::adc_word_t vc;          // tank voltage, polarity fixed
   hbc_pkg::adc_word_t ic;          // tank current, polarity fixed
   logic               valid;       // one-cycle strobe, no back-pressure
   logic               over_range;  // either channel hit a rail

   // capture side
   modport source (
      output vc,
      output ic,
      output valid,
      output over_range
   );

   // switching law side, takes the values in the valid cycle
   modport sink (
      input vc,
      input ic,
      input valid,
      input over_range
   );

endinterface

/* adc_capture.sv */
`timescale 1ns/1ps

module adc_capture (
   input  logic               ADA_DCO,
   input  logic               i_arst_n,
   input  logic               i_sample_stb,
   input  hbc_pkg::adc_word_t i_vc_data,
   input  hbc_pkg::adc_word_t i_ic_data,
   input  logic               i_vc_or,
   input  logic               i_ic_or,
   sample_if.source           o_smp
);

   // sensor polarity is inverted on the board
   // an over-range word is pushed to the opposite rail after inversion
   function automatic hbc_pkg::adc_word_t fix_sample(
      input hbc_pkg::adc_word_t raw,
      input logic               ovr
   );
      if (ovr) begin
         if (raw == hbc_pkg::ADC_MAX_NEG) begin
            return hbc_pkg::ADC_MAX_POS;
         end
         return hbc_pkg::ADC_MAX_NEG;
      end
      return -raw;                     // plain two's complement negate
   endfunction

   // ------------------------------------------------------------------------
   // sample registers, loaded only on the strobe
   // ------------------------------------------------------------------------
   always_ff @(posedge ADA_DCO) begin
      if (i_sample_stb) begin
         o_smp.vc         <= fix_sample(i_vc_data, i_vc_or);
         o_smp.ic         <= fix_sample(i_ic_data, i_ic_or);
         o_smp.over_range <= i_vc_or | i_ic_or;   // flag for either channel
      end
   end

   // valid trails the strobe by one cycle
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_smp.valid <= 1'b0;
      end else begin
         o_smp.valid <= i_sample_stb;
      end
   end

endmodule

/* angle_setting.sv */
`timescale 1ns/1ps

module angle_setting (
   input  logic          ADA_DCO,
   input  logic          i_arst_n,
   input  logic          i_inc,       // step up
   input  logic          i_dec,       // step down
   input  logic          i_home,      // back to home angle
   output hbc_pkg::phi_t o_phi
);

   hbc_pkg::phi_t phi_up;   // next value on increment
   hbc_pkg::phi_t phi_dn;   // next value on decrement

   // ------------------------------------------------------------------------
   // saturating step values
   // ------------------------------------------------------------------------
   always_comb begin
      if (o_phi >= hbc_pkg::PHI_MAX - hbc_pkg::PHI_STEP) begin
         phi_up = hbc_pkg::PHI_MAX;              // clip at the top
      end else begin
         phi_up = o_phi + hbc_pkg::PHI_STEP;
      end
   end

   always_comb begin
      if (o_phi < hbc_pkg::PHI_MIN + hbc_pkg::PHI_STEP) begin
         phi_dn = hbc_pkg::PHI_MIN;              // clip at the bottom
      end else begin
         phi_dn = o_phi - hbc_pkg::PHI_STEP;
      end
   end

   // ------------------------------------------------------------------------
   // phi register
   // home wins over inc, inc wins over dec
   // ------------------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_phi <= hbc_pkg::PHI_HOME;
      end else if (i_home) begin
         o_phi <= hbc_pkg::PHI_HOME;
      end else if (i_inc) begin
         o_phi <= phi_up;
      end else if (i_dec) begin
         o_phi <= phi_dn;
      end
   end

endmodule

/* switching_law.sv */
`timescale 1ns/1ps

module switching_law (
   input  logic           ADA_DCO,
   input  logic           i_arst_n,
   sample_if.sink         i_smp,
   input  hbc_pkg::phi_t  i_phi,
   output hbc_pkg::gate_t o_req
);

   hbc_pkg::surface_t vc_ext;    // vc widened to surface width
   hbc_pkg::surface_t surface;   // switching surface value
   hbc_pkg::surface_t win_pos;   // upper edge of the zero window
   hbc_pkg::surface_t win_neg;   // lower edge
   hbc_pkg::sigma_e   sigma;
   hbc_pkg::gate_t    pattern;

   // ------------------------------------------------------------------------
   // surface and window
   // ------------------------------------------------------------------------
   assign vc_ext  = i_smp.vc;                              // sign extends
   assign surface = i_smp.ic + (vc_ext >>> hbc_pkg::VC_SHIFT);

   // phi max 90 gives 5760, well inside 16 bits
   assign win_pos = hbc_pkg::surface_t'(i_phi) * hbc_pkg::PHI_SCALE;
   assign win_neg = -win_pos;

   // hybrid law with zero state inside the window
   always_comb begin
      if (surface > win_pos) begin
         sigma = hbc_pkg::SIGMA_POS;
      end else if (surface < win_neg) begin
         sigma = hbc_pkg::SIGMA_NEG;
      end else begin
         sigma = hbc_pkg::SIGMA_ZERO;
      end
   end

   // bridge state to gate word
   always_comb begin
      unique case (sigma)
         hbc_pkg::SIGMA_POS: pattern = hbc_pkg::GATE_POS;
         hbc_pkg::SIGMA_NEG: pattern = hbc_pkg::GATE_NEG;
         default:            pattern = hbc_pkg::GATE_ZERO;   // sigma zero
      endcase
   end

   // ------------------------------------------------------------------------
   // request register, updated per sample and held in between
   // ------------------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_req <= '0;
      end else if (i_smp.valid) begin
         o_req <= pattern;
      end
   end

endmodule

/* dead_time_gen.sv */
`timescale 1ns/1ps

module dead_time_gen (
   input  logic           ADA_DCO,
   input  logic           i_arst_n,
   input  hbc_pkg::gate_t i_req,    // gate request from the law
   output hbc_pkg::gate_t o_gate    // delayed turn-on, fast turn-off
);

   // on-time counter per gate, saturates at DEAD_LAST
   logic [hbc_pkg::DEAD_CNT_W-1:0] on_cnt [hbc_pkg::GATE_W];

   // ------------------------------------------------------------------------
   // each gate handled on its own
   // turn on after DEAD_CYCLES high samples, turn off on the next edge
   // ------------------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         for (int b = 0; b < hbc_pkg::GATE_W; b++) begin
            on_cnt[b] <= '0;
         end
         o_gate <= '0;
      end else begin
         for (int b = 0; b < hbc_pkg::GATE_W; b++) begin
            if (!i_req[b]) begin
               on_cnt[b] <= '0;                         // restart the delay
               o_gate[b] <= 1'b0;                       // off right away
            end else begin
               if (on_cnt[b] != hbc_pkg::DEAD_LAST) begin
                  on_cnt[b] <= on_cnt[b] + 1'b1;
               end
               o_gate[b] <= (on_cnt[b] == hbc_pkg::DEAD_LAST); // delay spent
            end
         end
      end
   end

endmodule

/* bridge_sequencer.sv */
`timescale 1ns/1ps

module bridge_sequencer (
   input  logic           ADA_DCO,
   input  logic           i_arst_n,
   input  logic           i_enable,   // converter on
   input  hbc_pkg::gate_t i_gate,     // dead-time gates from the law
   output hbc_pkg::gate_t o_gate,     // to the bridge drivers
   output logic           o_running,
   output logic           o_fault     // shoot-through seen
);

   hbc_pkg::seq_state_e           state;
   logic [hbc_pkg::PHASE_W-1:0]   phase;     // cycles spent in boot or precharge
   logic                          en_q;      // enable one cycle back
   logic                          shoot;     // both switches of a leg on
   hbc_pkg::gate_t                pattern;   // gate word for the current state

   assign shoot = (i_gate[hbc_pkg::LEG1_HI] & i_gate[hbc_pkg::LEG1_LO]) |
                  (i_gate[hbc_pkg::LEG2_HI] & i_gate[hbc_pkg::LEG2_LO]);

   // ------------------------------------------------------------------------
   // start-up FSM
   // ------------------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         state <= hbc_pkg::ST_IDLE;
         phase <= '0;
         en_q  <= 1'b0;
      end else begin
         en_q  <= i_enable;
         phase <= phase + 1'b1;
         if (!i_enable) begin
            state <= hbc_pkg::ST_IDLE;            // drop out from anywhere
            phase <= '0;
         end else begin
            unique case (state)
               hbc_pkg::ST_IDLE: begin
                  phase <= '0;
                  if (!en_q) begin
                     state <= hbc_pkg::ST_BOOT;   // enable rising edge
                  end
               end
               hbc_pkg::ST_BOOT: begin
                  if (phase == hbc_pkg::BOOT_LAST) begin
                     state <= hbc_pkg::ST_PRECHARGE;
                     phase <= '0;
                  end
               end
               hbc_pkg::ST_PRECHARGE: begin
                  if (phase == hbc_pkg::PRE_LAST) begin
                     state <= hbc_pkg::ST_RUN;
                     phase <= '0;
                  end
               end
               default: phase <= '0;             // run, hold
            endcase
         end
      end
   end

   // gate word per state
   always_comb begin
      unique case (state)
         hbc_pkg::ST_BOOT:      pattern = hbc_pkg::GATE_BOOT;  // low sides on
         hbc_pkg::ST_PRECHARGE: pattern = hbc_pkg::GATE_POS;   // forced +1
         hbc_pkg::ST_RUN:       pattern = i_gate;
         default:               pattern = '0;
      endcase
   end

   // ------------------------------------------------------------------------
   // outputs and shoot-through guard
   // ------------------------------------------------------------------------
   always_ff @(posedge ADA_DCO or negedge i_arst_n) begin
      if (!i_arst_n) begin
         o_gate    <= '0;
         o_running <= 1'b0;
         o_fault   <= 1'b0;
      end else begin
         if (!i_enable) begin
            o_fault <= 1'b0;                      // cleared only by disable
         end else if (shoot) begin
            o_fault <= 1'b1;
         end
         o_gate    <= (shoot | o_fault) ? '0 : pattern;
         o_running <= (state == hbc_pkg::ST_RUN); // aligned with o_gate
      end
   end

endmodule

/* hybrid_bridge_ctrl.sv */
`timescale 1ns/1ps

module hybrid_bridge_ctrl (
   input  logic               ADA_DCO,
   input  logic               i_arst_n,
   input  logic               i_enable,
   // tank ADC
   input  logic               i_sample_stb,   // new sample, one cycle
   input  hbc_pkg::adc_word_t i_vc_data,
   input  hbc_pkg::adc_word_t i_ic_data,
   input  logic               i_vc_or,
   input  logic               i_ic_or,
   // angle strobes
   input  logic               i_phi_inc,
   input  logic               i_phi_dec,
   input  logic               i_phi_home,
   // bridge
   output logic [3:0]         o_gate,         // {leg2 lo, leg1 lo, leg2 hi, leg1 hi}
   output logic [7:0]         o_phi,
   output logic               o_running,
   output logic               o_fault
);

   sample_if       smp ();   // capture to law
   hbc_pkg::gate_t req;      // law request
   hbc_pkg::gate_t dt_gate;  // after dead time

   // ------------------------------------------------------------------------
   // datapath
   // ------------------------------------------------------------------------
   adc_capture u_capture (
      .ADA_DCO      (ADA_DCO),
      .i_arst_n     (i_arst_n),
      .i_sample_stb (i_sample_stb),
      .i_vc_data    (i_vc_data),
      .i_ic_data    (i_ic_data),
      .i_vc_or      (i_vc_or),
      .i_ic_or      (i_ic_or),
      .o_smp        (smp.source)
   );

   angle_setting u_angle (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_inc    (i_phi_inc),
      .i_dec    (i_phi_dec),
      .i_home   (i_phi_home),
      .o_phi    (o_phi)
   );

   switching_law u_law (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_smp    (smp.sink),
      .i_phi    (o_phi),
      .o_req    (req)
   );

   dead_time_gen u_dead (
      .ADA_DCO  (ADA_DCO),
      .i_arst_n (i_arst_n),
      .i_req    (req),
      .o_gate   (dt_gate)
   );

   // start-up and guard
   bridge_sequencer u_seq (
      .ADA_DCO   (ADA_DCO),
      .i_arst_n  (i_arst_n),
      .i_enable  (i_enable),
      .i_gate    (dt_gate),
      .o_gate    (o_gate),
      .o_running (o_running),
      .o_fault   (o_fault)
   );

endmodule

/* hybrid_bridge_ctrl_assertions.sv */
`timescale 1ns/1ps

module hybrid_bridge_ctrl_assertions (
   input logic                ADA_DCO,
   input logic                i_arst_n,
   input hbc_pkg::gate_t      i_gate,      // sequencer output gates
   input logic                i_running,
   input logic                i_fault,
   input hbc_pkg::seq_state_e i_state
);

   int n_fail = 0;   // failures seen, read by the testbench top

   // no leg with high and low side on together
   a_no_shoot: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      !(i_gate[hbc_pkg::LEG1_HI] && i_gate[hbc_pkg::LEG1_LO]) &&
      !(i_gate[hbc_pkg::LEG2_HI] && i_gate[hbc_pkg::LEG2_LO]))
      else begin
         $error("both switches of one leg on");
         n_fail++;
      end

   // gates registered, so idle shows one edge later
   a_idle_off: assert property (@(posedge ADA_DCO) disable iff (!i_arst_n)
      (i_state == hbc_pkg::ST_IDLE) |=> (i_gate == '0 && !i_running))
      else begin
         $error("gates active outside start-up and run");
         n_fail++;
      end

   // first edge out of reset
   a_reset_clean: assert property (@(posedge ADA_DCO)
      $rose(i_arst_n) |-> (!i_fault && i_gate == '0))
      else begin
         $error("fault or gate set right after reset");
         n_fail++;
      end

endmodule

bind bridge_sequencer hybrid_bridge_ctrl_assertions u_sva (
   .ADA_DCO   (ADA_DCO),
   .i_arst_n  (i_arst_n),
   .i_gate    (o_gate),
   .i_running (o_running),
   .i_fault   (o_fault),
   .i_state   (state)
);

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_arst_n
);

   initial begin
      o_clk    = 1'b0;
      o_arst_n = 1'b0;                  // in reset from time zero
      repeat (4) @(posedge o_clk);      // four full cycles
      @(negedge o_clk);
      o_arst_n = 1'b1;                  // release mid cycle, away from the edge
   end

   always #20 o_clk = ~o_clk;           // 40 ns period

endmodule

/* tb_checker.sv */
`timescale 1ns/1ps

module tb_checker (
   input  logic        i_clk,
   input  logic [13:0] i_act,       // {fault, running, phi, gate} from the DUT
   input  logic        i_chk,       // compare request, one cycle
   input  logic [3:0]  i_mask,      // fields taking part, same order
   input  logic [13:0] i_exp,
   input  logic        i_test_end,  // close the current test
   input  int          i_test_id,
   output int          o_checks,
   output int          o_errors,
   output int          o_tests
);

   int n_checks = 0;
   int n_errors = 0;
   int n_tests  = 0;
   int t_checks = 0;   // current test only
   int t_errors = 0;

   assign o_checks = n_checks;
   assign o_errors = n_errors;
   assign o_tests  = n_tests;

   function automatic string test_name(input int id);
      case (id)
         1:       return "reset state";
         2:       return "start-up";
         3:       return "angle setting";
         4:       return "switching law";
         5:       return "over-range";
         6:       return "disable and restart";
         default: return "unknown";
      endcase
   endfunction

   task automatic compare(input string sig, input logic [7:0] exp_v, input logic [7:0] act_v);
      if (act_v !== exp_v) begin
         $display("Mismatch at %0t: %s expected 'h%0h, actual 'h%0h",
                  $time, sig, exp_v, act_v);
         n_errors++;
         t_errors++;
      end
   endtask

   // ------------------------------------------------------------------------
   // compare on the falling edge, outputs settled since the rising one
   // ------------------------------------------------------------------------
   always @(negedge i_clk) begin
      if (i_chk) begin
         n_checks++;
         t_checks++;
         if (i_mask[0])
            compare("o_gate", i_exp[3:0], i_act[3:0]);
         if (i_mask[1])
            compare("o_phi", i_exp[11:4], i_act[11:4]);
         if (i_mask[2])
            compare("o_running", i_exp[12], i_act[12]);
         if (i_mask[3])
            compare("o_fault", i_exp[13], i_act[13]);
      end
      if (i_test_end) begin
         $display("%s: %0d checks, %0d errors", test_name(i_test_id), t_checks, t_errors);
         n_tests++;
         t_checks = 0;
         t_errors = 0;
      end
   end

endmodule

/* tb_hybrid_bridge_ctrl.sv */
`timescale 1ns/1ps

module tb_hybrid_bridge_ctrl;

   // named as the DUT ports
   logic               ADA_DCO;
   logic               i_arst_n;
   logic               i_enable;
   logic               i_sample_stb;
   hbc_pkg::adc_word_t i_vc_data;
   hbc_pkg::adc_word_t i_ic_data;
   logic               i_vc_or;
   logic               i_ic_or;
   logic               i_phi_inc;
   logic               i_phi_dec;
   logic               i_phi_home;
   logic [3:0]         o_gate;
   logic [7:0]         o_phi;
   logic               o_running;
   logic               o_fault;

   logic               chk;         // compare request
   logic [3:0]         mask;        // fault, running, phi, gate
   logic [13:0]        exp_word;    // same field order
   logic               test_end;
   int                 test_id;
   int                 n_checks;
   int                 n_errors;
   int                 n_tests;
   int                 sva_fail;
   integer             seed;
   int                 model_phi;   // reference angle
   logic [3:0]         pick;        // random strobe and flag bits

   tb_clock_gen u_clk (
      .o_clk    (ADA_DCO),
      .o_arst_n (i_arst_n)
   );

   hybrid_bridge_ctrl uut (.*);

   tb_checker u_chk (
      .i_clk      (ADA_DCO),
      .i_act      ({o_fault, o_running, o_phi, o_gate}),
      .i_chk      (chk),
      .i_mask     (mask),
      .i_exp      (exp_word),
      .i_test_end (test_end),
      .i_test_id  (test_id),
      .o_checks   (n_checks),
      .o_errors   (n_errors),
      .o_tests    (n_tests)
   );

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------
   function automatic int next_phi(input int p, input logic inc, input logic dec,
                                   input logic home);
      if (home)
         return hbc_pkg::PHI_HOME;
      if (inc)
         return (p + hbc_pkg::PHI_STEP > hbc_pkg::PHI_MAX) ? hbc_pkg::PHI_MAX
                                                           : p + hbc_pkg::PHI_STEP;
      if (dec)
         return (p < hbc_pkg::PHI_STEP) ? hbc_pkg::PHI_MIN : p - hbc_pkg::PHI_STEP;
      return p;
   endfunction

   // inverted polarity, opposite rail on over-range
   function automatic int captured(input hbc_pkg::adc_word_t raw, input logic ovr);
      if (!ovr)
         return -int'(raw);
      return (int'(raw) == -8192) ? 8191 : -8192;
   endfunction

   function automatic logic [3:0] expected_gate(input int vc, input int ic, input int p);
      int surf;
      int win;
      surf = ic + ((vc >= 0) ? vc / 4 : -((3 - vc) / 4));   // floor of vc / 4
      win  = p * int'(hbc_pkg::PHI_SCALE);
      if (surf > win)
         return hbc_pkg::GATE_POS;
      if (surf < -win)
         return hbc_pkg::GATE_NEG;
      return hbc_pkg::GATE_ZERO;                           // inside the window
   endfunction

   // raw word that a plain negate can still represent
   function automatic hbc_pkg::adc_word_t random_word();
      hbc_pkg::adc_word_t w;
      w = $random(seed);
      return (w == hbc_pkg::ADC_MAX_NEG) ? 14'sd0 : w;
   endfunction

   // ------------------------------------------------------------------------
   // stimulus tasks
   // ------------------------------------------------------------------------
   task automatic next_cycle();
      @(posedge ADA_DCO);
      #1;                                    // drive just after the edge
   endtask

   task automatic expect_out(input logic [3:0] m, input logic [3:0] g, input int p,
                             input logic run, input logic flt);
      mask     = m;
      exp_word = {flt, run, p[7:0], g};
      chk      = 1'b1;
      next_cycle();
      chk      = 1'b0;
   endtask

   task automatic end_test();
      test_end = 1'b1;
      next_cycle();
      test_end = 1'b0;
      test_id++;
   endtask

   task automatic timeout_abort(input string what);
      $display("Timeout: %s", what);
      $display("Test failed");
      $finish;
   endtask

   task automatic wait_gate(input logic [3:0] g, input int limit, input string what);
      int n;
      n = 0;
      while (o_gate !== g) begin
         if (n == limit)
            timeout_abort(what);
         next_cycle();
         n++;
      end
   endtask

   task automatic wait_running(input logic lvl, input int limit, input string what);
      int n;
      n = 0;
      while (o_running !== lvl) begin
         if (n == limit)
            timeout_abort(what);
         next_cycle();
         n++;
      end
   endtask

   task automatic strobe_phi(input logic inc, input logic dec, input logic home);
      {i_phi_inc, i_phi_dec, i_phi_home} = {inc, dec, home};
      next_cycle();
      {i_phi_inc, i_phi_dec, i_phi_home} = 3'b000;
      model_phi = next_phi(model_phi, inc, dec, home);
      expect_out(4'b0010, 4'h0, model_phi, 1'b0, 1'b0);
   endtask

   task automatic set_phi(input int target);
      strobe_phi(1'b0, 1'b0, 1'b1);
      repeat (target / hbc_pkg::PHI_STEP) strobe_phi(1'b1, 1'b0, 1'b0);
   endtask

   // one strobe, data held, gate checked after the settle time
   task automatic send_sample(input hbc_pkg::adc_word_t vc, input hbc_pkg::adc_word_t ic,
                              input logic vor, input logic ior);
      i_vc_data    = vc;
      i_ic_data    = ic;
      i_vc_or      = vor;
      i_ic_or      = ior;
      i_sample_stb = 1'b1;
      next_cycle();
      i_sample_stb = 1'b0;
      repeat (12) next_cycle();
      expect_out(4'b1101, expected_gate(captured(vc, vor), captured(ic, ior), model_phi),
                 model_phi, 1'b1, 1'b0);
   endtask

   task automatic start_up();
      time t_en;
      int  spent;
      i_enable = 1'b1;
      t_en     = $time;
      wait_gate(hbc_pkg::GATE_BOOT, 4, "no bootstrap pattern after enable");
      wait_gate(hbc_pkg::GATE_POS, hbc_pkg::BOOT_CYCLES + 2, "no precharge pattern");
      spent = int'(($time - t_en) / 40);   // cycles since enable, 40 ns period
      wait_running(1'b1, hbc_pkg::BOOT_CYCLES + hbc_pkg::PRECHARGE_CYCLES + 4 - spent,
                   "o_running did not rise");
      expect_out(4'b1100, 4'h0, 0, 1'b1, 1'b0);
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin
      int n;
      seed         = 9;
      model_phi    = hbc_pkg::PHI_HOME;
      i_enable     = 1'b0;
      i_sample_stb = 1'b0;
      i_vc_data    = '0;
      i_ic_data    = '0;
      i_vc_or      = 1'b0;
      i_ic_or      = 1'b0;
      {i_phi_inc, i_phi_dec, i_phi_home} = 3'b000;
      {chk, test_end, mask, exp_word} = '0;
      test_id      = 1;

      n = 0;
      while (i_arst_n !== 1'b1) begin
         if (n == 8)
            timeout_abort("reset never released");
         next_cycle();
         n++;
      end

      expect_out(4'b1111, 4'h0, hbc_pkg::PHI_HOME, 1'b0, 1'b0);   // reset state
      end_test();

      start_up();
      end_test();

      for (int k = 0; k < 40; k++)
         strobe_phi(k < 20, k >= 20, 1'b0);      // run into both rails
      for (int k = 0; k < 40; k++) begin
         pick = $random(seed);
         strobe_phi(pick[0], pick[1], pick[2] & pick[3]);
      end
      end_test();

      for (int p = 0; p <= 90; p += 30) begin
         set_phi(p);
         send_sample(-14'sd8000, -14'sd8000, 1'b0, 1'b0);   // far above, +1
         send_sample(14'sd8000, 14'sd8000, 1'b0, 1'b0);     // far below, -1
         send_sample(14'sd40, -14'sd10, 1'b0, 1'b0);        // surface zero
         repeat (4) send_sample(random_word(), random_word(), 1'b0, 1'b0);
      end
      end_test();

      send_sample(14'h2000, 14'h2000, 1'b1, 1'b1);          // both to the top rail
      send_sample(14'h2000, 14'sd100, 1'b1, 1'b1);
      send_sample(14'sd123, 14'h2000, 1'b1, 1'b1);
      send_sample(14'sd0, -14'sd5, 1'b0, 1'b1);
      repeat (4) begin
         pick = $random(seed);
         send_sample(random_word(), random_word(), pick[0], pick[1]);
      end
      end_test();

      i_enable = 1'b0;
      wait_running(1'b0, 2, "o_running still high after disable");
      expect_out(4'b1101, 4'h0, 0, 1'b0, 1'b0);
      start_up();                                           // full sequence again
      end_test();

      sva_fail = uut.u_seq.u_sva.n_fail;
      $display("Summary: %0d tests, %0d checks, %0d mismatches, %0d assertion failures",
               n_tests, n_checks, n_errors, sva_fail);
      if (n_errors == 0 && sva_fail == 0 && n_tests == 6) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* hybrid_bridge_ctrl.f */
hbc_pkg.sv
sample_if.sv
adc_capture.sv
angle_setting.sv
switching_law.sv
dead_time_gen.sv
bridge_sequencer.sv
hybrid_bridge_ctrl.sv
hybrid_bridge_ctrl_assertions.sv
tb_clock_gen.sv
tb_checker.sv
tb_hybrid_bridge_ctrl.sv
